//--- bench/ttlMemBridgeSva.sv
`timescale 1ns/1ps
`default_nettype none

module ttlMemBridgeSva (
  input logic clk,
  input logic rst_n,
  input logic nWriteEnable,
  input logic ip2bus_mstrd_req,
  input logic ip2bus_mstwr_req,
  input logic bus2ip_mst_cmdack,
  input logic req,
  input logic ack,
  input logic dataOe
);

  // Master requests stay up until the master accepts them
  rdReqHold: assert property (@(posedge clk) disable iff (!rst_n)
    ip2bus_mstrd_req && !bus2ip_mst_cmdack |=> ip2bus_mstrd_req)
    else $error("Read request dropped before cmdack");

  wrReqHold: assert property (@(posedge clk) disable iff (!rst_n)
    ip2bus_mstwr_req && !bus2ip_mst_cmdack |=> ip2bus_mstwr_req)
    else $error("Write request dropped before cmdack");

  reqExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(ip2bus_mstrd_req && ip2bus_mstwr_req))
    else $error("Read and write requests both high");

  ackNeedsReq: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> req)
    else $error("Handshake ack rose without req");

  // TTL master owns the bus during a write
  noDriveOnWrite: assert property (@(posedge clk) disable iff (!rst_n)
    !nWriteEnable |-> !dataOe)
    else $error("Data bus driven while write enable is active");

endmodule

bind ttlMemBridge ttlMemBridgeSva sva (
  .clk               (clk),
  .rst_n             (rst_n),
  .nWriteEnable      (nWriteEnable),
  .ip2bus_mstrd_req  (ip2bus_mstrd_req),
  .ip2bus_mstwr_req  (ip2bus_mstwr_req),
  .bus2ip_mst_cmdack (bus2ip_mst_cmdack),
  .req               (cmdBus.req),
  .ack               (cmdBus.ack),
  .dataOe            (dataOe)
);

`default_nettype wire

//--- bench/ttlMemBridgeTb.sv
`timescale 1ns/1ps
`default_nettype none

module ttlMemBridgeTb
  import ttlBridgePkg::*;
();

  localparam int CLK_PERIOD_NS = 100;
  localparam int NUM_TESTS     = 6;
  localparam int OPS_PER_TEST  = 40;
  localparam int CLKS_PER_OP   = 12;
  localparam int WATCHDOG_NS   = NUM_TESTS * OPS_PER_TEST * CLKS_PER_OP * CLK_PERIOD_NS;

  logic                  clk;
  logic                  rst_n;
  logic                  nChipEnable;
  logic                  nOutputEnable;
  logic                  nWriteEnable;
  logic [ADDR_WIDTH-1:0] Address;
  wire  [DATA_WIDTH-1:0] Data;
  logic [MST_AWIDTH-1:0] MappedAddress;
  logic [MST_DWIDTH-1:0] ControlReg;
  logic [MST_DWIDTH-1:0] StatusReg;
  logic                  mstRdReq;
  logic                  mstWrReq;
  logic [MST_AWIDTH-1:0] mstAddr;
  logic [BE_WIDTH-1:0]   mstBe;
  logic [MST_DWIDTH-1:0] mstWrData;
  logic                  mstReset;
  logic                  cmdAck;
  logic                  cmplt;
  logic                  mstError;
  logic [MST_DWIDTH-1:0] mstRdData;
  logic                  srcRdyN;

  // Testbench side of the data bus
  logic                  tbDrive;
  logic [DATA_WIDTH-1:0] tbData;

  // Responder memory and the testbench's own shadow of it
  logic [7:0]            busMem [logic [31:0]];
  logic [7:0]            shadowMem [logic [31:0]];
  logic                  injectError;
  logic [MST_AWIDTH-1:0] lastReqAddr;
  logic [BE_WIDTH-1:0]   lastReqBe;
  logic [MST_DWIDTH-1:0] lastReqWrData;
  logic [STATE_WIDTH-1:0] lastReqState;

  // Checks waiting for the compare process
  string                 nameQ [$];
  logic [31:0]           gotQ [$];
  logic [31:0]           expQ [$];
  event                  checkQueued;
  int                    checkCount;
  int                    errorCount;
  int                    testErrStart;
  int unsigned           seedDummy;

  assign Data = tbDrive ? tbData : {DATA_WIDTH{1'bz}};

  ttlMemBridge uut (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .nChipEnable            (nChipEnable),
    .nOutputEnable          (nOutputEnable),
    .nWriteEnable           (nWriteEnable),
    .Address                (Address),
    .Data                   (Data),
    .MappedAddress          (MappedAddress),
    .ControlReg             (ControlReg),
    .StatusReg              (StatusReg),
    .ip2bus_mstrd_req       (mstRdReq),
    .ip2bus_mstwr_req       (mstWrReq),
    .ip2bus_mst_addr        (mstAddr),
    .ip2bus_mst_be          (mstBe),
    .ip2bus_mstwr_d         (mstWrData),
    .ip2bus_mst_reset       (mstReset),
    .bus2ip_mst_cmdack      (cmdAck),
    .bus2ip_mst_cmplt       (cmplt),
    .bus2ip_mst_error       (mstError),
    .bus2ip_mstrd_d         (mstRdData),
    .bus2ip_mstrd_src_rdy_n (srcRdyN)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  // Contents of a never written location
  function automatic logic [7:0] fillByte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] memByte(input logic [31:0] a);
    if (busMem.exists(a)) begin
      return busMem[a];
    end
    return fillByte(a);
  endfunction

  // Expected read byte from the shadow at base plus TTL address
  function automatic logic [7:0] refByte(input logic [31:0] base, input logic [15:0] addr);
    logic [31:0] a;
    a = base + {16'h0, addr};
    if (shadowMem.exists(a)) begin
      return shadowMem[a];
    end
    return fillByte(a);
  endfunction

  task automatic queueCheck(input string name, input logic [31:0] got,
                            input logic [31:0] expVal);
    nameQ.push_back(name);
    gotQ.push_back(got);
    expQ.push_back(expVal);
    -> checkQueued;
  endtask

  task automatic waitBusy(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (StatusReg[STAT_BUSY] !== level && n < 40);
    if (StatusReg[STAT_BUSY] !== level) begin
      $display("Busy did not go to %0d within 40 cycles at %0t", level, $time);
      errorCount++;
    end
  endtask

  task automatic ttlWrite(input logic [15:0] addr, input logic [7:0] data);
    @(negedge clk);
    Address      = addr;
    tbData       = data;
    tbDrive      = 1'b1;
    nChipEnable  = 1'b0;
    nWriteEnable = 1'b0;
    waitBusy(1'b1);
    waitBusy(1'b0);
    nChipEnable  = 1'b1;
    nWriteEnable = 1'b1;
    tbDrive      = 1'b0;
    shadowMem[MappedAddress + {16'h0, addr}] = data;
    repeat (2) @(negedge clk);
  endtask

  task automatic ttlRead(input logic [15:0] addr, output logic [7:0] data);
    @(negedge clk);
    Address       = addr;
    nChipEnable   = 1'b0;
    nOutputEnable = 1'b0;
    waitBusy(1'b1);
    waitBusy(1'b0);
    // Byte is driven while the cycle is still open
    data          = Data;
    nChipEnable   = 1'b1;
    nOutputEnable = 1'b1;
    repeat (2) @(negedge clk);
  endtask

  // Master port model with cmdack after a random wait and cmplt one cycle later
  task automatic serveRequest();
    logic [31:0] wordAddr;
    logic        isWrite;
    lastReqState = StatusReg[STAT_STATE_LSB +: STATE_WIDTH];
    repeat ($urandom_range(5, 0)) @(negedge clk);
    isWrite       = mstWrReq;
    lastReqAddr   = mstAddr;
    lastReqBe     = mstBe;
    lastReqWrData = mstWrData;
    wordAddr      = {mstAddr[31:2], 2'b00};
    cmdAck        = 1'b1;
    @(negedge clk);
    cmdAck   = 1'b0;
    cmplt    = 1'b1;
    mstError = injectError;
    for (int i = 0; i < BE_WIDTH; i++) begin
      if (!isWrite) begin
        mstRdData[8*i +: 8] = memByte(wordAddr + i);
      end else if (mstBe[i] && !injectError) begin
        busMem[wordAddr + i] = mstWrData[8*i +: 8];
      end
    end
    srcRdyN = isWrite;
    @(negedge clk);
    cmplt    = 1'b0;
    mstError = 1'b0;
    srcRdyN  = 1'b1;
  endtask

  initial begin : responder
    cmdAck    = 1'b0;
    cmplt     = 1'b0;
    mstError  = 1'b0;
    mstRdData = '0;
    srcRdyN   = 1'b1;
    forever begin
      @(negedge clk);
      if (mstRdReq || mstWrReq) begin
        serveRequest();
      end
    end
  end

  initial begin : compare
    string       name;
    logic [31:0] got;
    logic [31:0] expVal;
    forever begin
      @(checkQueued);
      while (gotQ.size() > 0) begin
        name   = nameQ.pop_front();
        got    = gotQ.pop_front();
        expVal = expQ.pop_front();
        checkCount++;
        assert (got === expVal) else begin
          $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expVal);
          errorCount++;
        end
      end
    end
  end

  task automatic finishTest(input int num, input string name);
    @(negedge clk);
    $display("Test %0d %s: %s", num, name, (errorCount == testErrStart) ? "ok" : "failed");
    testErrStart = errorCount;
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [7:0]  rdByte;
    logic [15:0] addr;
    logic        sawReq;
    logic        sawBusy;
    seedDummy     = $urandom(32'hf7e5);
    rst_n         = 1'b0;
    nChipEnable   = 1'b1;
    nOutputEnable = 1'b1;
    nWriteEnable  = 1'b1;
    Address       = '0;
    tbDrive       = 1'b0;
    tbData        = '0;
    MappedAddress = 32'h0001_0000;
    ControlReg    = 32'h1;
    injectError   = 1'b0;
    checkCount    = 0;
    errorCount    = 0;
    testErrStart  = 0;
    repeat (5) @(negedge clk);
    queueCheck("ip2bus_mst_reset", {31'h0, mstReset}, 32'h1);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    queueCheck("ip2bus_mst_reset", {31'h0, mstReset}, 32'h0);

    addr = 16'h0012;
    ttlWrite(addr, 8'hc3);
    queueCheck("ip2bus_mst_be", {28'h0, lastReqBe}, 32'h1 << addr[1:0]);
    queueCheck("ip2bus_mstwr_d", lastReqWrData, {4{8'hc3}});
    queueCheck("StatusReg.state", {27'h0, lastReqState}, {27'h0, ExWrReq});
    ttlRead(addr, rdByte);
    queueCheck("Data", {24'h0, rdByte}, {24'h0, refByte(MappedAddress, addr)});
    finishTest(1, "write then read back");

    // Preloaded word with four distinct lanes
    for (int i = 0; i < 4; i++) begin
      busMem[MappedAddress + 32'h40 + i]    = 8'h1e + 8'(i * 8'h35);
      shadowMem[MappedAddress + 32'h40 + i] = 8'h1e + 8'(i * 8'h35);
    end
    for (int i = 0; i < 4; i++) begin
      addr = 16'h0040 + 16'(i);
      ttlRead(addr, rdByte);
      queueCheck("Data", {24'h0, rdByte}, {24'h0, refByte(MappedAddress, addr)});
    end
    finishTest(2, "byte lanes of one word");

    MappedAddress = 32'h0002_0000;
    addr = 16'h0105;
    ttlRead(addr, rdByte);
    queueCheck("ip2bus_mst_addr", lastReqAddr, MappedAddress + {16'h0, addr});
    queueCheck("StatusReg.state", {27'h0, lastReqState}, {27'h0, ExRdReq});
    queueCheck("Data", {24'h0, rdByte}, {24'h0, refByte(MappedAddress, addr)});
    finishTest(3, "new mapped base");

    for (int n = 0; n < OPS_PER_TEST; n++) begin
      addr = 16'($urandom_range(31, 0));
      if ($urandom_range(1, 0) == 1) begin
        ttlWrite(addr, 8'($urandom));
      end else begin
        ttlRead(addr, rdByte);
        queueCheck("Data", {24'h0, rdByte}, {24'h0, refByte(MappedAddress, addr)});
      end
    end
    finishTest(4, "random reads and writes");

    injectError = 1'b1;
    ttlRead(16'h0020, rdByte);
    injectError = 1'b0;
    queueCheck("StatusReg.error", {31'h0, StatusReg[STAT_ERROR]}, 32'h1);
    ttlRead(16'h0021, rdByte);
    queueCheck("Data", {24'h0, rdByte}, {24'h0, refByte(MappedAddress, 16'h0021)});
    queueCheck("StatusReg.error", {31'h0, StatusReg[STAT_ERROR]}, 32'h1);
    ControlReg = 32'h3;
    @(negedge clk);
    ControlReg = 32'h1;
    @(negedge clk);
    queueCheck("StatusReg.error", {31'h0, StatusReg[STAT_ERROR]}, 32'h0);
    finishTest(5, "sticky master error");

    ControlReg = 32'h0;
    @(negedge clk);
    Address       = 16'h0030;
    nChipEnable   = 1'b0;
    nOutputEnable = 1'b0;
    sawReq        = 1'b0;
    sawBusy       = 1'b0;
    repeat (10) begin
      @(negedge clk);
      sawReq  = sawReq | mstRdReq | mstWrReq;
      sawBusy = sawBusy | StatusReg[STAT_BUSY];
    end
    queueCheck("StatusReg.enabled", {31'h0, StatusReg[STAT_ENABLED]}, 32'h0);
    queueCheck("ip2bus_mst_req", {31'h0, sawReq}, 32'h0);
    queueCheck("StatusReg.busy", {31'h0, sawBusy}, 32'h0);
    nChipEnable   = 1'b1;
    nOutputEnable = 1'b1;
    // Let the synchronizers see the strobes closed before enabling again
    repeat (4) @(negedge clk);
    ControlReg = 32'h1;
    finishTest(6, "bridge disabled");

    $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checkCount, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hdl/ttlBridgePkg.sv
hdl/busCmdIf.sv
hdl/ttlCycleDecode.sv
hdl/mstCmdExecute.sv
hdl/busResultDrive.sv
hdl/ttlMemBridge.sv
bench/ttlMemBridgeSva.sv
bench/ttlMemBridgeTb.sv

//--- hdl/busCmdIf.sv
`timescale 1ns/1ps
`default_nettype none

interface busCmdIf import ttlBridgePkg::*; ();

  // Four-phase handshake
  logic                  req;
  logic                  ack;

  // Command fields, stable while req is high
  logic                  isWrite;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wrData;

  // Result fields, valid while ack is high
  logic [DATA_WIDTH-1:0] rdData;
  logic                  error;

  modport decode (output req, isWrite, addr, wrData,
                  input  ack, rdData, error);

  modport execute (input  req, isWrite, addr, wrData,
                   output ack, rdData, error);

  modport monitor (input req, ack, isWrite, addr, wrData, rdData, error);

endinterface

`default_nettype wire

//--- hdl/busResultDrive.sv
`timescale 1ns/1ps
`default_nettype none

module busResultDrive
  import ttlBridgePkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  logic                  errClear,
  input  logic                  nChipEnable,
  input  logic                  nOutputEnable,
  busCmdIf.monitor              cmd,
  input  execState_e            execState,
  output logic [DATA_WIDTH-1:0] dataOut,
  output logic                  dataOe,
  output logic [MST_DWIDTH-1:0] StatusReg
);

  logic ackQ;
  logic ackRise;
  logic errSticky;
  logic wrActive;

  assign ackRise  = cmd.ack && !ackQ;
  assign wrActive = cmd.isWrite && (cmd.req || cmd.ack);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ackQ      <= 1'b0;
      errSticky <= 1'b0;
    end else begin
      ackQ <= cmd.ack;
      // A new error takes priority over a clear in the same cycle
      if (ackRise && cmd.error) begin
        errSticky <= 1'b1;
      end else if (errClear) begin
        errSticky <= 1'b0;
      end
    end
  end

  // Returned byte, a write reads back what it wrote
  always_ff @(posedge clk) begin
    if (ackRise) begin
      dataOut <= cmd.isWrite ? cmd.wrData : cmd.rdData;
    end
  end

  // Drive the bus only for an open read cycle
  assign dataOe = !nChipEnable && !nOutputEnable && !wrActive;

  always_comb begin
    StatusReg                 = '0;
    StatusReg[STAT_ENABLED]   = enable;
    StatusReg[STAT_BUSY]      = cmd.req || cmd.ack;
    StatusReg[STAT_ERROR]     = errSticky;
    StatusReg[STAT_STATE_LSB +: STATE_WIDTH] = execState;
  end

endmodule

`default_nettype wire

//--- hdl/mstCmdExecute.sv
`timescale 1ns/1ps
`default_nettype none

module mstCmdExecute
  import ttlBridgePkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  busCmdIf.execute              cmd,
  input  logic [MST_AWIDTH-1:0] MappedAddress,
  output logic                  ip2bus_mstrd_req,
  output logic                  ip2bus_mstwr_req,
  output logic [MST_AWIDTH-1:0] ip2bus_mst_addr,
  output logic [BE_WIDTH-1:0]   ip2bus_mst_be,
  output logic [MST_DWIDTH-1:0] ip2bus_mstwr_d,
  input  logic                  bus2ip_mst_cmdack,
  input  logic                  bus2ip_mst_cmplt,
  input  logic                  bus2ip_mst_error,
  input  logic [MST_DWIDTH-1:0] bus2ip_mstrd_d,
  input  logic                  bus2ip_mstrd_src_rdy_n,
  output execState_e            execState
);

  execState_e            state;
  logic                  errFlag;
  logic                  mstActive;

  // Command payload, loaded when a request is accepted
  logic [MST_AWIDTH-1:0] mstAddr;
  logic [BE_WIDTH-1:0]   mstBe;
  logic [1:0]            byteSel;
  mstWord_u              wrWord;
  mstWord_u              rdWord;

  assign mstActive = (state == ExRdReq) || (state == ExRdResp) ||
                     (state == ExWrReq) || (state == ExWrResp);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ExIdle;
      errFlag <= 1'b0;
    end else begin
      case (state)
        ExIdle: begin
          if (cmd.req) begin
            errFlag <= 1'b0;
            state   <= cmd.isWrite ? ExWrReq : ExRdReq;
          end
        end
        // Request held until the master accepts it
        ExRdReq: begin
          if (bus2ip_mst_cmdack) begin
            state <= bus2ip_mst_cmplt ? ExDone : ExRdResp;
          end
        end
        ExRdResp: begin
          if (bus2ip_mst_cmplt) begin
            state <= ExDone;
          end
        end
        ExWrReq: begin
          if (bus2ip_mst_cmdack) begin
            state <= bus2ip_mst_cmplt ? ExDone : ExWrResp;
          end
        end
        ExWrResp: begin
          if (bus2ip_mst_cmplt) begin
            state <= ExDone;
          end
        end
        // Hold ack until decode has dropped req
        ExDone: begin
          if (!cmd.req) begin
            state <= ExIdle;
          end
        end
        default: begin
          state <= ExIdle;
        end
      endcase

      if (mstActive && bus2ip_mst_error) begin
        errFlag <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ExIdle) && cmd.req) begin
      mstAddr <= MappedAddress + {{(MST_AWIDTH-ADDR_WIDTH){1'b0}}, cmd.addr};
      mstBe   <= {{(BE_WIDTH-1){1'b0}}, 1'b1} << cmd.addr[1:0];
      byteSel <= cmd.addr[1:0];
      // Same byte on every lane, the byte enable picks the one written
      for (int i = 0; i < BE_WIDTH; i++) begin
        wrWord.bytes[i] <= cmd.wrData;
      end
    end
    if (((state == ExRdReq) || (state == ExRdResp)) && !bus2ip_mstrd_src_rdy_n) begin
      rdWord.word <= bus2ip_mstrd_d;
    end
  end

  assign ip2bus_mstrd_req = (state == ExRdReq);
  assign ip2bus_mstwr_req = (state == ExWrReq);
  assign ip2bus_mst_addr  = mstAddr;
  assign ip2bus_mst_be    = mstBe;
  assign ip2bus_mstwr_d   = wrWord.word;

  assign cmd.ack    = (state == ExDone);
  assign cmd.rdData = rdWord.bytes[byteSel];
  assign cmd.error  = errFlag;

  assign execState = state;

endmodule

`default_nettype wire

//--- hdl/ttlBridgePkg.sv
`default_nettype none

package ttlBridgePkg;

  // TTL memory bus
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 8;

  // Master command port
  localparam int MST_AWIDTH = 32;
  localparam int MST_DWIDTH = 32;
  localparam int BE_WIDTH   = MST_DWIDTH / 8;

  // Status word layout
  localparam int STAT_ENABLED   = 0;
  localparam int STAT_BUSY      = 1;
  localparam int STAT_ERROR     = 2;
  localparam int STAT_STATE_LSB = 27;
  localparam int STATE_WIDTH    = 5;

  // Execute stage states, reported in the top bits of the status word
  typedef enum logic [STATE_WIDTH-1:0] {
    ExIdle   = 5'd0,
    ExRdReq  = 5'd1,
    ExRdResp = 5'd2,
    ExWrReq  = 5'd3,
    ExWrResp = 5'd4,
    ExDone   = 5'd5
  } execState_e;

  // One master data word, seen whole or as byte lanes
  typedef union packed {
    logic [MST_DWIDTH-1:0]               word;
    logic [BE_WIDTH-1:0][DATA_WIDTH-1:0] bytes;
  } mstWord_u;

endpackage

`default_nettype wire

//--- hdl/ttlCycleDecode.sv
`timescale 1ns/1ps
`default_nettype none

module ttlCycleDecode
  import ttlBridgePkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  logic                  nChipEnable,
  input  logic                  nOutputEnable,
  input  logic                  nWriteEnable,
  input  logic [ADDR_WIDTH-1:0] Address,
  input  logic [DATA_WIDTH-1:0] dataIn,
  busCmdIf.decode               cmd
);

  // Two-flop synchronizers for the strobes, bit 1 is the synced value
  logic [1:0] ceSync;
  logic [1:0] oeSync;
  logic [1:0] weSync;

  // Address and data delayed to line up with the synced strobes
  logic [ADDR_WIDTH-1:0] addrS1;
  logic [ADDR_WIDTH-1:0] addrS2;
  logic [DATA_WIDTH-1:0] dataS1;
  logic [DATA_WIDTH-1:0] dataS2;

  // Request side of the handshake
  logic                  reqQ;
  logic                  isWriteQ;
  logic [ADDR_WIDTH-1:0] addrQ;
  logic [DATA_WIDTH-1:0] wrDataQ;

  // Cycle tracking
  logic [ADDR_WIDTH-1:0] lastAddr;
  logic                  armed;
  logic                  ceN;
  logic                  oeN;
  logic                  weN;
  logic                  startCycle;

  assign ceN = ceSync[1];
  assign oeN = oeSync[1];
  assign weN = weSync[1];

  // New command only with the handshake fully idle and the last cycle closed
  assign startCycle = enable && armed && !reqQ && !cmd.ack &&
                      !ceN && (!weN || !oeN);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ceSync   <= 2'b11;
      oeSync   <= 2'b11;
      weSync   <= 2'b11;
      reqQ     <= 1'b0;
      armed    <= 1'b1;
      lastAddr <= '0;
    end else begin
      ceSync <= {ceSync[0], nChipEnable};
      oeSync <= {oeSync[0], nOutputEnable};
      weSync <= {weSync[0], nWriteEnable};

      if (startCycle) begin
        reqQ     <= 1'b1;
        armed    <= 1'b0;
        lastAddr <= addrS2;
      end else begin
        // Drop req once execute has answered
        if (reqQ && cmd.ack) begin
          reqQ <= 1'b0;
        end
        // Chip enable high or a new address closes the previous cycle
        if (ceN || (addrS2 != lastAddr)) begin
          armed <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    addrS1 <= Address;
    addrS2 <= addrS1;
    dataS1 <= dataIn;
    dataS2 <= dataS1;
    if (startCycle) begin
      // Write wins when both strobes are low
      isWriteQ <= !weN;
      addrQ    <= addrS2;
      wrDataQ  <= dataS2;
    end
  end

  assign cmd.req     = reqQ;
  assign cmd.isWrite = isWriteQ;
  assign cmd.addr    = addrQ;
  assign cmd.wrData  = wrDataQ;

endmodule

`default_nettype wire

//--- hdl/ttlMemBridge.sv
`timescale 1ns/1ps
`default_nettype none

module ttlMemBridge
  import ttlBridgePkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // TTL memory bus
  input  logic                  nChipEnable,
  input  logic                  nOutputEnable,
  input  logic                  nWriteEnable,
  input  logic [ADDR_WIDTH-1:0] Address,
  inout  wire  [DATA_WIDTH-1:0] Data,
  // Host registers
  input  logic [MST_AWIDTH-1:0] MappedAddress,
  input  logic [MST_DWIDTH-1:0] ControlReg,
  output logic [MST_DWIDTH-1:0] StatusReg,
  // Master command port
  output logic                  ip2bus_mstrd_req,
  output logic                  ip2bus_mstwr_req,
  output logic [MST_AWIDTH-1:0] ip2bus_mst_addr,
  output logic [BE_WIDTH-1:0]   ip2bus_mst_be,
  output logic [MST_DWIDTH-1:0] ip2bus_mstwr_d,
  output logic                  ip2bus_mst_reset,
  input  logic                  bus2ip_mst_cmdack,
  input  logic                  bus2ip_mst_cmplt,
  input  logic                  bus2ip_mst_error,
  input  logic [MST_DWIDTH-1:0] bus2ip_mstrd_d,
  input  logic                  bus2ip_mstrd_src_rdy_n
);

  logic                  enable;
  logic                  errClear;
  logic [DATA_WIDTH-1:0] dataOut;
  logic                  dataOe;
  execState_e            execState;

  busCmdIf cmdBus ();

  assign enable           = ControlReg[0];
  assign errClear         = ControlReg[1];
  assign ip2bus_mst_reset = ~rst_n;

  // Bidirectional data bus
  assign Data = dataOe ? dataOut : {DATA_WIDTH{1'bz}};

  ttlCycleDecode decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .nChipEnable   (nChipEnable),
    .nOutputEnable (nOutputEnable),
    .nWriteEnable  (nWriteEnable),
    .Address       (Address),
    .dataIn        (Data),
    .cmd           (cmdBus.decode)
  );

  mstCmdExecute execute (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .cmd                    (cmdBus.execute),
    .MappedAddress          (MappedAddress),
    .ip2bus_mstrd_req       (ip2bus_mstrd_req),
    .ip2bus_mstwr_req       (ip2bus_mstwr_req),
    .ip2bus_mst_addr        (ip2bus_mst_addr),
    .ip2bus_mst_be          (ip2bus_mst_be),
    .ip2bus_mstwr_d         (ip2bus_mstwr_d),
    .bus2ip_mst_cmdack      (bus2ip_mst_cmdack),
    .bus2ip_mst_cmplt       (bus2ip_mst_cmplt),
    .bus2ip_mst_error       (bus2ip_mst_error),
    .bus2ip_mstrd_d         (bus2ip_mstrd_d),
    .bus2ip_mstrd_src_rdy_n (bus2ip_mstrd_src_rdy_n),
    .execState              (execState)
  );

  busResultDrive result (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .errClear      (errClear),
    .nChipEnable   (nChipEnable),
    .nOutputEnable (nOutputEnable),
    .cmd           (cmdBus.monitor),
    .execState     (execState),
    .dataOut       (dataOut),
    .dataOe        (dataOe),
    .StatusReg     (StatusReg)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module ttlMemBridgeTb -o simTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
